// ==== logic/core_settings.svh ====
/*
 * Core configuration macros
 * Word width, register count, memory serial width and the I/O select bit
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Word, instruction and address width
`define CORE_DATA_WIDTH 16

// General purpose registers
`define CORE_REG_NUM 8

// Width of read and write serials on the memory port
`define CORE_SERIAL_WIDTH 4

// Address bit that selects the I/O region
`define CORE_IO_ADDR_BIT 15

`endif

// ==== logic/CorePkg.sv ====
/*
 * CorePkg
 * Datapath vector types, memory serial types, opcode and execute state enums
 */
`include "core_settings.svh"

package CorePkg;

    typedef logic [`CORE_DATA_WIDTH-1:0] DataPath;
    typedef logic [`CORE_DATA_WIDTH-1:0] AddrPath;
    typedef logic [`CORE_DATA_WIDTH-1:0] PC_Path;
    typedef logic [`CORE_DATA_WIDTH-1:0] InsnPath;
    typedef logic [$clog2(`CORE_REG_NUM)-1:0] RegNumPath;

    // Serials handed out by the memory
    typedef logic [`CORE_SERIAL_WIDTH-1:0] MemAccessSerial;
    typedef logic [`CORE_SERIAL_WIDTH-1:0] MemWriteSerial;

    typedef logic [7:0] SerialDataPath;

    // Retired instruction count
    typedef logic [`CORE_DATA_WIDTH-1:0] DebugRegister;

    // Instruction bits 15:12
    typedef enum logic [3:0] {
        LI   = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        XOR  = 4'd3,
        LD   = 4'd4,
        ST   = 4'd5,
        BNZ  = 4'd6,
        HALT = 4'd7
    } OpCode;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        MEM,
        WAIT,
        HALTED
    } ExecState;

endpackage

// ==== logic/MemoryAccessController.sv ====
/*
 * MemoryAccessController
 * Single outstanding access to the external tagged memory port
 */
`timescale 1ns/100ps

module MemoryAccessController import CorePkg::*; (
input
    logic clk,
    logic rstN,
    logic fetchReq,
    AddrPath fetchAddr,
    logic dataReq,
    logic dataWrite,
    AddrPath dataAddr,
    DataPath dataWData,
    logic memAccessReadBusy,
    logic memAccessWriteBusy,
    MemAccessSerial nextMemReadSerial,
    MemWriteSerial nextMemWriteSerial,
    logic memReadDataReady,
    DataPath memReadData,
    MemAccessSerial memReadSerial,
    logic memAccessResponseValid,
    MemWriteSerial memAccessResponseSerial,
output
    logic fetchDone,
    InsnPath fetchData,
    logic dataDone,
    DataPath dataRData,
    AddrPath memAccessAddr,
    DataPath memAccessWriteData,
    logic memAccessRE,
    logic memAccessWE
);
    typedef enum logic [1:0] {IDLE, ISSUED, WAITING} CtrlState;

    CtrlState state;
    logic isFetch;
    logic isWrite;
    logic doneReg;
    AddrPath addrReg;
    DataPath wdataReg;
    DataPath rdataReg;
    MemAccessSerial pendingSerial;
    logic respMatch;

    assign memAccessRE = (state == ISSUED) && !isWrite && !memAccessReadBusy;
    assign memAccessWE = (state == ISSUED) && isWrite && !memAccessWriteBusy;
    assign memAccessAddr = addrReg;
    assign memAccessWriteData = wdataReg;

    // Stale serials fall through and are ignored
    assign respMatch = isWrite ?
        (memAccessResponseValid && memAccessResponseSerial == pendingSerial) :
        (memReadDataReady && memReadSerial == pendingSerial);

    assign fetchDone = doneReg && isFetch;
    assign dataDone = doneReg && !isFetch;
    assign fetchData = rdataReg;
    assign dataRData = rdataReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            doneReg <= 1'b0;
            isFetch <= 1'b0;
            isWrite <= 1'b0;
        end else begin
            doneReg <= 1'b0;
            case (state)
                IDLE: begin
                    // Requester still holds its request during the done pulse
                    if (fetchReq && !fetchDone) begin
                        isFetch <= 1'b1;
                        isWrite <= 1'b0;
                        state <= ISSUED;
                    end else if (dataReq && !dataDone) begin
                        isFetch <= 1'b0;
                        isWrite <= dataWrite;
                        state <= ISSUED;
                    end
                end
                ISSUED: begin
                    if (memAccessRE || memAccessWE) begin
                        state <= WAITING;
                    end
                end
                default: begin
                    if (respMatch) begin
                        doneReg <= 1'b1;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            addrReg <= (fetchReq && !fetchDone) ? fetchAddr : dataAddr;
            wdataReg <= dataWData;
        end
        if (memAccessRE) begin
            pendingSerial <= nextMemReadSerial;
        end else if (memAccessWE) begin
            pendingSerial <= nextMemWriteSerial;
        end
        if (state == WAITING && respMatch && !isWrite) begin
            rdataReg <= memReadData;
        end
    end

endmodule : MemoryAccessController

// ==== logic/FetchUnit.sv ====
/*
 * FetchUnit
 * Program counter, instruction register and fetch request handshake
 */
`timescale 1ns/100ps

module FetchUnit import CorePkg::*; (
input
    logic clk,
    logic rstN,
    logic fetchStart,
    logic fetchDone,
    InsnPath fetchData,
    logic pcStep,
    logic branchTaken,
    logic [7:0] branchOffset,
output
    logic fetchReq,
    PC_Path pc,
    InsnPath insn,
    logic insnValid
);
    PC_Path offsetExt;

    // Signed branch offset, applied on top of PC+1
    assign offsetExt = branchTaken ? PC_Path'({{8{branchOffset[7]}}, branchOffset}) : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
            fetchReq <= 1'b0;
            insnValid <= 1'b0;
        end else begin
            if (fetchDone) begin
                fetchReq <= 1'b0;
            end else if (fetchStart) begin
                fetchReq <= 1'b1;
            end
            insnValid <= fetchDone;
            if (pcStep) begin
                pc <= pc + PC_Path'(1) + offsetExt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            insn <= fetchData;
        end
    end

endmodule : FetchUnit

// ==== logic/ExecUnit.sv ====
/*
 * ExecUnit
 * Decode and execute FSM, register file, ALU, load and store sequencing
 */
`timescale 1ns/100ps
`include "core_settings.svh"

module ExecUnit import CorePkg::*; (
input
    logic clk,
    logic rstN,
    InsnPath insn,
    logic insnValid,
    PC_Path pc,
    logic dataDone,
    DataPath dataRData,
output
    logic fetchStart,
    logic pcStep,
    logic branchTaken,
    logic [7:0] branchOffset,
    logic dataReq,
    logic dataWrite,
    AddrPath dataAddr,
    DataPath dataWData,
    logic ioWrite,
    SerialDataPath ioData,
    PC_Path lastCommittedPC,
    DebugRegister debugRegister
);
    ExecState state;
    DataPath regFile [`CORE_REG_NUM];

    OpCode opCode;
    RegNumPath rd, rs1, rs2;
    DataPath rdVal, rs1Val, rs2Val;
    DataPath aluResult;
    logic ioAccess;
    logic memOp;
    logic retire;
    logic regWE;

    assign opCode = OpCode'(insn[15:12]);
    assign rd = insn[11:9];
    assign rs1 = insn[8:6];
    assign rs2 = insn[5:3];
    assign rdVal = regFile[rd];
    assign rs1Val = regFile[rs1];
    assign rs2Val = regFile[rs2];

    always_comb begin
        case (opCode)
            LI: aluResult = DataPath'(insn[7:0]);
            ADD: aluResult = rs1Val + rs2Val;
            SUB: aluResult = rs1Val - rs2Val;
            XOR: aluResult = rs1Val ^ rs2Val;
            default: aluResult = dataRData;
        endcase
    end

    // Stores with the I/O bit set bypass memory
    assign ioAccess = rs1Val[`CORE_IO_ADDR_BIT];
    assign memOp = (opCode == LD) || (opCode == ST && !ioAccess);
    assign ioWrite = (state == DECODE) && (opCode == ST) && ioAccess;
    assign ioData = rdVal[7:0];

    assign retire = ((state == DECODE) && !memOp) || ((state == MEM) && dataDone);
    assign pcStep = retire && (opCode != HALT);
    assign branchTaken = (opCode == BNZ) && (rdVal != '0);
    assign branchOffset = insn[7:0];
    assign fetchStart = (state == FETCH);

    assign regWE = ((state == DECODE) && (opCode inside {LI, ADD, SUB, XOR}))
        || ((state == MEM) && dataDone && (opCode == LD));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `CORE_REG_NUM; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWE) begin
            regFile[rd] <= aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= FETCH;
            dataReq <= 1'b0;
            lastCommittedPC <= '0;
            debugRegister <= '0;
        end else begin
            case (state)
                FETCH: state <= WAIT;
                WAIT: begin
                    if (insnValid) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    if (opCode == HALT) begin
                        state <= HALTED;
                    end else if (memOp) begin
                        dataReq <= 1'b1;
                        state <= MEM;
                    end else begin
                        state <= FETCH;
                    end
                end
                MEM: begin
                    if (dataDone) begin
                        dataReq <= 1'b0;
                        state <= FETCH;
                    end
                end
                default: state <= HALTED;
            endcase
            if (retire) begin
                lastCommittedPC <= pc;
                debugRegister <= debugRegister + DebugRegister'(1);
            end
        end
    end

    // Memory request payload
    always_ff @(posedge clk) begin
        if (state == DECODE && memOp) begin
            dataWrite <= (opCode == ST);
            dataAddr <= rs1Val;
            dataWData <= rdVal;
        end
    end

endmodule : ExecUnit

// ==== logic/IoUnit.sv ====
/*
 * IoUnit
 * Serial output register with a one-cycle write pulse
 */
`timescale 1ns/100ps

module IoUnit import CorePkg::*; (
input
    logic clk,
    logic rstN,
    logic ioWrite,
    SerialDataPath ioData,
output
    logic serialWE,
    SerialDataPath serialWriteData
);
    logic accept;

    // No new pulse while the previous one is still high
    assign accept = ioWrite && !serialWE;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            serialWE <= 1'b0;
        end else begin
            serialWE <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            serialWriteData <= ioData;
        end
    end

endmodule : IoUnit

// ==== logic/Core.sv ====
/*
 * Core
 * Top level connecting fetch, execute, memory access and I/O units
 */
`timescale 1ns/100ps

module Core import CorePkg::*; (
input
    logic clk,
    logic rstN,
    MemAccessSerial nextMemReadSerial,
    MemWriteSerial nextMemWriteSerial,
    DataPath memReadData,
    logic memReadDataReady,
    MemAccessSerial memReadSerial,
    logic memAccessResponseValid,
    MemWriteSerial memAccessResponseSerial,
    logic memAccessReadBusy,
    logic memAccessWriteBusy,
output
    DebugRegister debugRegister,
    PC_Path lastCommittedPC,
    AddrPath memAccessAddr,
    DataPath memAccessWriteData,
    logic memAccessRE,
    logic memAccessWE,
    logic serialWE,
    SerialDataPath serialWriteData
);
    // Fetch path
    logic fetchReq, fetchDone, fetchStart, insnValid;
    InsnPath fetchData, insn;
    PC_Path pc;
    logic pcStep, branchTaken;
    logic [7:0] branchOffset;

    // Data path
    logic dataReq, dataWrite, dataDone;
    AddrPath dataAddr;
    DataPath dataWData, dataRData;

    logic ioWrite;
    SerialDataPath ioData;

    MemoryAccessController memoryAccessController (
        .clk, .rstN,
        .fetchReq, .fetchAddr(pc),
        .dataReq, .dataWrite, .dataAddr, .dataWData,
        .memAccessReadBusy, .memAccessWriteBusy,
        .nextMemReadSerial, .nextMemWriteSerial,
        .memReadDataReady, .memReadData, .memReadSerial,
        .memAccessResponseValid, .memAccessResponseSerial,
        .fetchDone, .fetchData, .dataDone, .dataRData,
        .memAccessAddr, .memAccessWriteData, .memAccessRE, .memAccessWE
    );

    FetchUnit fetchUnit (
        .clk, .rstN, .fetchStart, .fetchDone, .fetchData,
        .pcStep, .branchTaken, .branchOffset,
        .fetchReq, .pc, .insn, .insnValid
    );

    ExecUnit execUnit (
        .clk, .rstN, .insn, .insnValid, .pc, .dataDone, .dataRData,
        .fetchStart, .pcStep, .branchTaken, .branchOffset,
        .dataReq, .dataWrite, .dataAddr, .dataWData,
        .ioWrite, .ioData, .lastCommittedPC, .debugRegister
    );

    IoUnit ioUnit (
        .clk, .rstN, .ioWrite, .ioData, .serialWE, .serialWriteData
    );

endmodule : Core

// ==== bench/ClockGen.sv ====
/*
 * ClockGen
 * 40 ns clock and a restartable four-cycle synchronous reset
 */
`timescale 1ns/100ps

module ClockGen (
input
    logic resetReq,
output
    logic clk,
    logic rstN
);
    logic [2:0] resetCycles = 3'd4;
    logic resetReleased = 1'b0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset stays low while cycles remain
    always @(posedge clk) begin
        if (resetReq) begin
            resetCycles <= 3'd4;
        end else if (resetCycles != 3'd0) begin
            resetCycles <= resetCycles - 3'd1;
        end
    end

    // Reset follows the counter 2 ns after the edge
    always @(posedge clk) begin
        #2;
        resetReleased = (resetCycles == 3'd0);
    end

    assign rstN = resetReleased;

endmodule : ClockGen

// ==== bench/Core_checker.sv ====
/*
 * Core_checker
 * Memory port and reset assertions, bound to Core
 */
`timescale 1ns/100ps

module Core_checker (
input
    logic clk,
    logic rstN,
    logic memAccessRE,
    logic memAccessWE,
    logic memAccessReadBusy,
    logic memAccessWriteBusy,
    logic serialWE
);
    // Strobes quiet right after a reset cycle
    assert property (@(posedge clk) !rstN |=> !memAccessRE && !memAccessWE && !serialWE)
        else $error("memory or serial strobe high after reset");

    assert property (@(posedge clk) disable iff (!rstN) !(memAccessRE && memAccessReadBusy))
        else $error("read request issued while read busy");

    assert property (@(posedge clk) disable iff (!rstN) !(memAccessWE && memAccessWriteBusy))
        else $error("write request issued while write busy");

    assert property (@(posedge clk) disable iff (!rstN) !(memAccessRE && memAccessWE))
        else $error("read and write requests in the same cycle");

    // One request pulse per access
    assert property (@(posedge clk) disable iff (!rstN) memAccessRE |=> !memAccessRE)
        else $error("read request held longer than one cycle");

endmodule : Core_checker

bind Core Core_checker coreChecker (.*);

// ==== bench/CoreBench.sv ====
/*
 * CoreBench
 * Random programs, tagged memory responder with stale serials,
 * ISA reference model, compare tasks, watchdog and report
 */
`timescale 1ns/100ps
`include "core_settings.svh"

module CoreBench import CorePkg::*; ();
    localparam int programCount = 5;
    localparam int programWords = 64;

    logic clk, rstN, resetReq;
    MemAccessSerial nextMemReadSerial, memReadSerial;
    MemWriteSerial nextMemWriteSerial, memAccessResponseSerial;
    DataPath memReadData, memAccessWriteData;
    logic memReadDataReady, memAccessResponseValid;
    logic memAccessReadBusy, memAccessWriteBusy;
    DebugRegister debugRegister, lastCount, expCount;
    PC_Path lastCommittedPC;
    AddrPath memAccessAddr, reqAddr;
    logic memAccessRE, memAccessWE, serialWE;
    SerialDataPath serialWriteData;

    // Program in words 0..63, data in 64..127
    DataPath mem [128];
    DataPath modelMem [128];
    PC_Path expPc [$];
    SerialDataPath expChar [$];
    AddrPath expStoreAddr [$];
    DataPath expStoreData [$];

    int retiredSeen, errorCount, checkCount, readDelay, writeDelay;
    logic [31:0] lfsrState;
    logic readSeen, writeSeen;
    DataPath reqData, readDataHeld;
    MemAccessSerial readSerialHeld;
    MemWriteSerial writeSerialHeld;

    ClockGen clockGen (.resetReq, .clk, .rstN);
    Core UUT (.*);

    // Galois LFSR, one step per bit
    function automatic logic [31:0] takeBits(int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
        return bits;
    endfunction

    function automatic InsnPath encodeReg(OpCode op, RegNumPath rd, RegNumPath rs1,
                                          RegNumPath rs2);
        return {op, rd, rs1, rs2, 3'b000};
    endfunction

    function automatic InsnPath encodeImm(OpCode op, RegNumPath rd, logic [7:0] imm);
        return {op, rd, 1'b0, imm};
    endfunction

    task automatic reportValue(string name, logic [31:0] expected, logic [31:0] actual);
        errorCount++;
        $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    task automatic compareData(string name, DataPath expected, DataPath actual);
        checkCount++;
        if (actual !== expected) begin
            reportValue(name, 32'(expected), 32'(actual));
        end
    endtask

    task automatic comparePC(string name, PC_Path expected, PC_Path actual);
        checkCount++;
        if (actual !== expected) begin
            reportValue(name, 32'(expected), 32'(actual));
        end
    endtask

    task automatic compareChar(string name, SerialDataPath expected, SerialDataPath actual);
        checkCount++;
        if (actual !== expected) begin
            reportValue(name, 32'(expected), 32'(actual));
        end
    endtask

    task automatic compareCount(string name, DebugRegister expected, DebugRegister actual);
        checkCount++;
        if (actual !== expected) begin
            reportValue(name, 32'(expected), 32'(actual));
        end
    endtask

    // r7 points at I/O, r6 at data words, r0 stays zero
    task automatic generateProgram();
        logic [2:0] kind;
        RegNumPath rd, rs1, rs2;
        logic [7:0] offset;
        mem[0] = encodeImm(LI, 3'd7, 8'h80);
        mem[1] = encodeReg(SUB, 3'd7, 3'd0, 3'd7);
        mem[2] = encodeImm(LI, 3'd6, 8'd64);
        for (int i = 3; i < programWords - 1; i++) begin
            kind = 3'(takeBits(3));
            rd = 3'(1 + takeBits(2));
            rs1 = 3'(takeBits(3));
            rs2 = 3'(takeBits(3));
            case (kind)
                3'd0: mem[i] = encodeImm(LI, rd, 8'(takeBits(8)));
                3'd1: mem[i] = encodeReg(ADD, rd, rs1, rs2);
                3'd2: mem[i] = encodeReg(SUB, rd, rs1, rs2);
                3'd3: mem[i] = encodeReg(XOR, rd, rs1, rs2);
                3'd4: mem[i] = encodeImm(LI, 3'd6, 8'(64 + takeBits(6)));
                3'd5: mem[i] = encodeReg(LD, rd, 3'd6, 3'd0);
                3'd6: mem[i] = encodeReg(ST, rs1, (takeBits(1) != 0) ? 3'd7 : 3'd6, 3'd0);
                default: begin
                    // Forward only, never past HALT
                    offset = 8'(takeBits(3));
                    if (i + 1 + int'(offset) > programWords - 1) begin
                        offset = '0;
                    end
                    mem[i] = encodeImm(BNZ, rs1, offset);
                end
            endcase
        end
        mem[programWords - 1] = encodeImm(HALT, 3'd0, 8'd0);
        for (int a = 64; a < 128; a++) begin
            mem[a] = DataPath'(takeBits(16));
        end
    endtask

    task automatic runModel();
        DataPath regs [`CORE_REG_NUM];
        PC_Path pc;
        InsnPath ins;
        DataPath a, b, d;
        RegNumPath rd;
        logic done;
        for (int r = 0; r < `CORE_REG_NUM; r++) begin
            regs[r] = '0;
        end
        modelMem = mem;
        expPc.delete();
        expChar.delete();
        expStoreAddr.delete();
        expStoreData.delete();
        expCount = '0;
        pc = '0;
        done = 1'b0;
        while (!done) begin
            ins = modelMem[pc[6:0]];
            rd = ins[11:9];
            a = regs[ins[8:6]];
            b = regs[ins[5:3]];
            d = regs[rd];
            expPc.push_back(pc);
            expCount++;
            pc++;
            case (OpCode'(ins[15:12]))
                LI: regs[rd] = {8'h00, ins[7:0]};
                ADD: regs[rd] = a + b;
                SUB: regs[rd] = a - b;
                XOR: regs[rd] = a ^ b;
                LD: regs[rd] = modelMem[a[6:0]];
                ST: begin
                    if (a[`CORE_IO_ADDR_BIT]) begin
                        expChar.push_back(d[7:0]);
                    end else begin
                        expStoreAddr.push_back(a);
                        expStoreData.push_back(d);
                        modelMem[a[6:0]] = d;
                    end
                end
                BNZ: begin
                    if (d != '0) begin
                        pc = pc + {{8{ins[7]}}, ins[7:0]};
                    end
                end
                default: done = 1'b1;
            endcase
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        readSeen = memAccessRE;
        writeSeen = memAccessWE;
        reqAddr = memAccessAddr;
        reqData = memAccessWriteData;
        if (rstN && memAccessWE) begin
            if (expStoreAddr.size() == 0) begin
                errorCount++;
                $display("Memory write to %h when the program has no store left", reqAddr);
            end else begin
                compareData("store address", expStoreAddr.pop_front(), reqAddr);
                compareData("store data", expStoreData.pop_front(), reqData);
            end
        end
        if (rstN && serialWE) begin
            if (expChar.size() == 0) begin
                errorCount++;
                $display("Serial write of %h when no character was expected", serialWriteData);
            end else begin
                compareChar("serial character", expChar.pop_front(), serialWriteData);
            end
        end
        if (rstN && debugRegister != lastCount) begin
            if (expPc.size() == 0) begin
                errorCount++;
                $display("Core retired an instruction after the program ended");
            end else begin
                comparePC("retired PC", expPc.pop_front(), lastCommittedPC);
            end
            retiredSeen++;
        end
        lastCount = debugRegister;
    end

    // Memory responder
    always @(posedge clk) begin
        #2;
        if (readSeen) begin
            readSerialHeld = nextMemReadSerial;
            readDataHeld = mem[reqAddr[6:0]];
            nextMemReadSerial = nextMemReadSerial + MemAccessSerial'(1);
            readDelay = 1 + int'(takeBits(3)) % 6;
        end
        if (writeSeen) begin
            mem[reqAddr[6:0]] = reqData;
            writeSerialHeld = nextMemWriteSerial;
            nextMemWriteSerial = nextMemWriteSerial + MemWriteSerial'(1);
            writeDelay = 1 + int'(takeBits(3)) % 6;
        end
        memReadDataReady = 1'b0;
        if (readDelay == 1) begin
            memReadDataReady = 1'b1;
            memReadSerial = readSerialHeld;
            memReadData = readDataHeld;
        end else if (takeBits(3) == 0) begin
            // Stale serial, junk data
            memReadDataReady = 1'b1;
            memReadSerial = readSerialHeld - MemAccessSerial'(1);
            memReadData = DataPath'(takeBits(16));
        end
        memAccessResponseValid = 1'b0;
        if (writeDelay == 1) begin
            memAccessResponseValid = 1'b1;
            memAccessResponseSerial = writeSerialHeld;
        end else if (takeBits(3) == 0) begin
            memAccessResponseValid = 1'b1;
            memAccessResponseSerial = writeSerialHeld - MemWriteSerial'(1);
        end
        if (readDelay > 0) begin
            readDelay--;
        end
        if (writeDelay > 0) begin
            writeDelay--;
        end
        memAccessReadBusy = (takeBits(2) == 0);
        memAccessWriteBusy = (takeBits(2) == 0);
    end

    initial begin
        lfsrState = 32'h20ab9755;
        errorCount = 0;
        checkCount = 0;
        resetReq = 1'b0;
        nextMemReadSerial = '0;
        nextMemWriteSerial = '0;
        memReadData = '0;
        memReadDataReady = 1'b0;
        memReadSerial = '0;
        memAccessResponseValid = 1'b0;
        memAccessResponseSerial = '0;
        memAccessReadBusy = 1'b0;
        memAccessWriteBusy = 1'b0;
        readSeen = 1'b0;
        writeSeen = 1'b0;
        readDelay = 0;
        writeDelay = 0;
        readSerialHeld = '0;
        writeSerialHeld = '0;
        lastCount = '0;
        for (int p = 0; p < programCount; p++) begin
            generateProgram();
            runModel();
            retiredSeen = 0;
            @(posedge clk);
            #2 resetReq = 1'b1;
            @(posedge clk);
            #2 resetReq = 1'b0;
            // Done once HALT has retired
            while (retiredSeen < int'(expCount)) begin
                @(negedge clk);
            end
            compareCount("retired count", expCount, debugRegister);
            for (int a = 64; a < 128; a++) begin
                compareData("data word", modelMem[a], mem[a]);
            end
            if (expChar.size() != 0 || expStoreAddr.size() != 0) begin
                errorCount++;
                $display("Program %0d ended with characters or stores still missing", p);
            end
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, 64 instructions of 30 cycles per program
    initial begin
        #(programCount * 64 * 30 * 40);
        $display("Timeout: the core did not finish all programs in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule : CoreBench

// ==== src.f ====
+incdir+logic
logic/CorePkg.sv
logic/MemoryAccessController.sv
logic/FetchUnit.sv
logic/ExecUnit.sv
logic/IoUnit.sv
logic/Core.sv
bench/ClockGen.sv
bench/Core_checker.sv
bench/CoreBench.sv

// ==== Makefile ====
# Verilator lint and simulation of the Core testbench
TOP := CoreBench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
